/* verilog/spi_xip_pkg.sv */
// SPI XIP bridge shared definitions
// register map, CTL bit positions, internal bus and shift command types
`default_nettype none

package spi_xip_pkg;

  // register offsets, RXD0/RXD1 share the TXD0/TXD1 slots
  localparam logic [4:0] addr_txd0 = 5'h00;
  localparam logic [4:0] addr_txd1 = 5'h04;
  localparam logic [4:0] addr_ctl  = 5'h10;
  localparam logic [4:0] addr_div  = 5'h14;
  localparam logic [4:0] addr_cs   = 5'h18;

  localparam int ctl_go         = 8;
  localparam int ctl_rx_negedge = 9;
  localparam int ctl_tx_negedge = 10;
  localparam int ctl_lsb        = 11;
  localparam int ctl_ie         = 12;
  localparam int ctl_ass        = 13;
  localparam int ctl_rd_endian  = 14;
  localparam int ctl_cpol       = 15;

  localparam logic [7:0] flash_read_op = 8'h03;

  // go, auto select, irq enable, launch on falling edge, swapped readback, 64 bits
  localparam logic [31:0] flash_ctl_word = (32'd1 << ctl_go) | (32'd1 << ctl_ass) |
                                           (32'd1 << ctl_ie) | (32'd1 << ctl_tx_negedge) |
                                           (32'd1 << ctl_rd_endian) | 32'd64;

  typedef struct packed {
    logic [4:0]  addr;
    logic        sel;
    logic        enable;
    logic        write;
    logic [31:0] wdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
    logic        slverr;
  } apb_rsp_t;

  typedef struct packed {
    logic        go;          // one cycle
    logic [6:0]  char_len;    // 0 means 64
    logic        lsb;
    logic        tx_negedge;
    logic        rx_negedge;
    logic        cpol;
    logic [15:0] div;
  } shift_cmd_t;

  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [7:0]  opcode;    // first on the wire
      logic [23:0] addr24;
    } frame;
  } txd1_u;

endpackage

`default_nettype wire

/* verilog/xip_bridge.sv */
// XIP bridge front end
// decodes the flash window, runs the flash read sequence or a single
// pass-through access, and steps each access onto the internal APB bus
`timescale 1ns/1ps
`default_nettype none

module xip_bridge #(
  parameter logic [31:0] flash_base  = 32'h3000_0000,
  parameter logic [31:0] flash_limit = 32'h3fff_ffff
) (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic [31:0]             paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [31:0]             pwdata,
  output logic                    pready,
  output logic [31:0]             prdata,
  output logic                    pslverr,
  output spi_xip_pkg::apb_req_t   req,
  input  spi_xip_pkg::apb_rsp_t   rsp,
  input  logic                    irq_flag,
  output logic                    irq
);

  typedef enum logic [2:0] {
    cmd_idle,
    cmd_csr,
    cmd_wr_txd0,
    cmd_wr_txd1,
    cmd_wr_ctl,
    cmd_wait_irq,
    cmd_rd_rxd0
  } cmd_state_t;

  typedef enum logic {
    st_setup,
    st_access
  } step_state_t;

  cmd_state_t          cmd_state;
  cmd_state_t          cmd_next;
  step_state_t         step_state;
  logic [23:0]         addr_q;
  logic                access;
  logic                is_flash;
  logic                step_go;
  logic                fire;
  logic                finish;
  logic                irq_mask;
  spi_xip_pkg::txd1_u  txd1_word;

  assign access   = psel && penable && !pready;  // not on the completion cycle
  assign is_flash = (paddr >= flash_base) && (paddr <= flash_limit);
  assign step_go  = (cmd_state != cmd_idle) && (cmd_state != cmd_wait_irq);
  assign fire     = (step_state == st_access) && rsp.ready;
  assign finish   = fire && ((cmd_state == cmd_csr) || (cmd_state == cmd_rd_rxd0));

  always_comb begin
    txd1_word.frame.opcode = spi_xip_pkg::flash_read_op;
    txd1_word.frame.addr24 = addr_q;
  end

  always_comb begin
    cmd_next = cmd_state;
    case (cmd_state)
      cmd_idle: begin
        if (access && !(is_flash && pwrite)) begin
          cmd_next = is_flash ? cmd_wr_txd0 : cmd_csr;
        end
      end
      cmd_csr, cmd_rd_rxd0: if (fire) cmd_next = cmd_idle;
      cmd_wr_txd0:          if (fire) cmd_next = cmd_wr_txd1;
      cmd_wr_txd1:          if (fire) cmd_next = cmd_wr_ctl;
      cmd_wr_ctl:           if (fire) cmd_next = cmd_wait_irq;
      cmd_wait_irq:         if (irq_flag) cmd_next = cmd_rd_rxd0;
      default:              cmd_next = cmd_idle;
    endcase
  end

  always_comb begin
    req.sel    = (step_state == st_access) || step_go;
    req.enable = (step_state == st_access);
    req.write  = 1'b1;
    req.wdata  = '0;
    req.addr   = spi_xip_pkg::addr_txd0;
    case (cmd_state)
      cmd_csr: begin
        req.addr  = addr_q[4:0];
        req.write = pwrite;
        req.wdata = pwdata;  // held by the master until pready
      end
      cmd_wr_txd1: begin
        req.addr  = spi_xip_pkg::addr_txd1;
        req.wdata = txd1_word.raw;
      end
      cmd_wr_ctl: begin
        req.addr  = spi_xip_pkg::addr_ctl;
        req.wdata = spi_xip_pkg::flash_ctl_word;
      end
      cmd_rd_rxd0: req.write = 1'b0;
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      cmd_state  <= cmd_idle;
      step_state <= st_setup;
      pready     <= 1'b0;
      pslverr    <= 1'b0;
      irq_mask   <= 1'b0;
    end else begin
      cmd_state <= cmd_next;
      pready    <= 1'b0;
      pslverr   <= 1'b0;
      case (step_state)
        st_setup:  if (step_go) step_state <= st_access;
        default:   if (rsp.ready) step_state <= st_setup;
      endcase
      if ((cmd_state == cmd_idle) && access && is_flash && pwrite) begin
        pready  <= 1'b1;  // flash is read only
        pslverr <= 1'b1;
      end
      if (finish) begin
        pready  <= 1'b1;
        pslverr <= rsp.slverr;
      end
      // hide the flag raised by our own read until software clears it
      if ((cmd_state == cmd_wait_irq) && irq_flag) begin
        irq_mask <= 1'b1;
      end else if (!irq_flag) begin
        irq_mask <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((cmd_state == cmd_idle) && access) addr_q <= {paddr[23:2], 2'b00};
    if (finish) prdata <= rsp.rdata;
  end

  assign irq = irq_flag && !irq_mask &&
               ((cmd_state == cmd_idle) || (cmd_state == cmd_csr));

endmodule

`default_nettype wire

/* verilog/spi_regs.sv */
// SPI master register file
// internal APB slave with TX/RX data, control, divider and chip select,
// launches transfers and raises the completion flag
`timescale 1ns/1ps
`default_nettype none

module spi_regs #(
  parameter int cs_num = 2
) (
  input  logic                      clk,
  input  logic                      resetn,
  input  spi_xip_pkg::apb_req_t     req,
  output spi_xip_pkg::apb_rsp_t     rsp,
  output spi_xip_pkg::shift_cmd_t   cmd,
  output logic [63:0]               tx_data,
  input  logic                      busy,
  input  logic                      done,
  input  logic [63:0]               rx_data,
  output logic                      irq_flag,
  output logic [cs_num-1:0]         cs_n
);

  logic [31:0]         txd0_q;
  spi_xip_pkg::txd1_u  txd1_q;
  logic [15:0]         ctl_q;
  logic [15:0]         div_q;
  logic [cs_num-1:0]   cs_q;
  logic [cs_num-1:0]   ass_sel;
  logic [63:0]         rx_q;
  logic [31:0]         rxd0;
  logic                go_q;
  logic                wr;
  logic                ctl_take;
  logic                running;

  assign wr      = req.sel && req.enable && req.write;
  assign running = busy || go_q;
  // GO while a transfer runs drops the whole write
  assign ctl_take = wr && (req.addr == spi_xip_pkg::addr_ctl) &&
                    !(req.wdata[spi_xip_pkg::ctl_go] && running);

  assign rxd0 = ctl_q[spi_xip_pkg::ctl_rd_endian] ?
                {rx_q[7:0], rx_q[15:8], rx_q[23:16], rx_q[31:24]} : rx_q[31:0];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      ctl_q    <= '0;
      div_q    <= '0;
      cs_q     <= '0;
      go_q     <= 1'b0;
      irq_flag <= 1'b0;
    end else begin
      go_q <= ctl_take && req.wdata[spi_xip_pkg::ctl_go];
      if (ctl_take) begin
        ctl_q                   <= req.wdata[15:0];
        ctl_q[spi_xip_pkg::ctl_go] <= 1'b0;  // go lives in go_q and busy
      end
      if (wr && (req.addr == spi_xip_pkg::addr_div)) div_q <= req.wdata[15:0];
      if (wr && (req.addr == spi_xip_pkg::addr_cs)) cs_q <= req.wdata[cs_num-1:0];
      if (done && ctl_q[spi_xip_pkg::ctl_ie]) begin
        irq_flag <= 1'b1;
      end else if (ctl_take) begin
        irq_flag <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr && (req.addr == spi_xip_pkg::addr_txd0)) txd0_q <= req.wdata;
    if (wr && (req.addr == spi_xip_pkg::addr_txd1)) txd1_q.raw <= req.wdata;
    if (done) rx_q <= rx_data;
  end

  always_comb begin
    rsp.ready  = req.sel && req.enable;  // no wait states
    rsp.slverr = 1'b0;
    rsp.rdata  = '0;
    case (req.addr)
      spi_xip_pkg::addr_txd0: rsp.rdata = rxd0;
      spi_xip_pkg::addr_txd1: rsp.rdata = rx_q[63:32];
      spi_xip_pkg::addr_ctl: begin
        rsp.rdata[15:0]               = ctl_q;
        rsp.rdata[spi_xip_pkg::ctl_go] = running;
      end
      spi_xip_pkg::addr_div:  rsp.rdata[15:0] = div_q;
      spi_xip_pkg::addr_cs:   rsp.rdata[cs_num-1:0] = cs_q;
      default:                rsp.slverr = rsp.ready;  // unmapped offset
    endcase
  end

  assign cmd.go         = go_q;
  assign cmd.char_len   = ctl_q[6:0];
  assign cmd.lsb        = ctl_q[spi_xip_pkg::ctl_lsb];
  assign cmd.tx_negedge = ctl_q[spi_xip_pkg::ctl_tx_negedge];
  assign cmd.rx_negedge = ctl_q[spi_xip_pkg::ctl_rx_negedge];
  assign cmd.cpol       = ctl_q[spi_xip_pkg::ctl_cpol];
  assign cmd.div        = div_q;

  assign tx_data = {txd1_q.raw, txd0_q};

  // auto select falls back to device 0, the boot flash
  always_comb begin
    ass_sel = cs_q;
    if (cs_q == '0) ass_sel[0] = 1'b1;
  end

  assign cs_n = ctl_q[spi_xip_pkg::ctl_ass] ? ~(busy ? ass_sel : '0) : ~cs_q;

endmodule

`default_nettype wire

/* verilog/spi_shifter.sv */
// SPI shift engine
// divides the system clock into sclk and moves up to 64 bits each way,
// with selectable launch and sample edges, bit order and idle polarity
`timescale 1ns/1ps
`default_nettype none

module spi_shifter (
  input  logic                      clk,
  input  logic                      resetn,
  input  spi_xip_pkg::shift_cmd_t   cmd,
  input  logic [63:0]               tx_data,
  output logic                      sclk,
  output logic                      mosi,
  input  logic                      miso,
  output logic                      busy,
  output logic                      done,
  output logic [63:0]               rx_data
);

  logic [15:0] div_q;
  logic [15:0] cnt;
  logic [6:0]  len_q;
  logic [6:0]  len_in;
  logic        lsb_q;
  logic        tx_neg_q;
  logic        rx_neg_q;
  logic [7:0]  edge_cnt;
  logic        sampled;
  logic [63:0] tx_sr;
  logic [63:0] rx_sr;
  logic        start;
  logic        tick;
  logic        to_high;
  logic        launch;
  logic        sample;
  logic        last;

  assign len_in  = (cmd.char_len == 7'd0) ? 7'd64 : cmd.char_len;
  assign start   = !busy && cmd.go;
  assign tick    = busy && (cnt == div_q);  // sclk toggles this cycle
  assign to_high = ~sclk;
  assign launch  = tick && (to_high ^ tx_neg_q);
  assign sample  = tick && (to_high ^ rx_neg_q);
  assign last    = tick && (edge_cnt == ({len_q, 1'b0} - 8'd1));

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      sclk     <= 1'b0;
      cnt      <= '0;
      edge_cnt <= '0;
      sampled  <= 1'b0;
      div_q    <= '0;
      len_q    <= 7'd64;
      lsb_q    <= 1'b0;
      tx_neg_q <= 1'b0;
      rx_neg_q <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        sclk <= cmd.cpol;  // idle level follows CPOL
        if (cmd.go) begin
          busy     <= 1'b1;
          cnt      <= '0;
          edge_cnt <= '0;
          sampled  <= 1'b0;
          div_q    <= cmd.div;
          len_q    <= len_in;
          lsb_q    <= cmd.lsb;
          tx_neg_q <= cmd.tx_negedge;
          rx_neg_q <= cmd.rx_negedge;
        end
      end else if (tick) begin
        cnt      <= '0;
        sclk     <= ~sclk;
        edge_cnt <= edge_cnt + 8'd1;
        if (sample) sampled <= 1'b1;
        if (last) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end else begin
        cnt <= cnt + 16'd1;
      end
    end
  end

  // first bit is on the line at start, later launch edges advance it
  always_ff @(posedge clk) begin
    if (start) begin
      tx_sr <= cmd.lsb ? tx_data : (tx_data << (7'd64 - len_in));
      rx_sr <= '0;
    end else begin
      if (launch && sampled) tx_sr <= lsb_q ? (tx_sr >> 1) : (tx_sr << 1);
      if (sample) rx_sr <= lsb_q ? {miso, rx_sr[63:1]} : {rx_sr[62:0], miso};
    end
  end

  assign mosi    = busy && (lsb_q ? tx_sr[0] : tx_sr[63]);
  assign rx_data = lsb_q ? (rx_sr >> (7'd64 - len_q)) : rx_sr;

endmodule

`default_nettype wire

/* verilog/spi_xip_top.sv */
// SPI XIP flash controller top level
// APB3 slave port in front of the bridge, register file and shift engine
`timescale 1ns/1ps
`default_nettype none

module spi_xip_top #(
  parameter logic [31:0] flash_base  = 32'h3000_0000,
  parameter logic [31:0] flash_limit = 32'h3fff_ffff,
  parameter int          cs_num      = 2
) (
  input  logic               clk,
  input  logic               resetn,
  input  logic [31:0]        paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [31:0]        pwdata,
  input  logic [3:0]         pstrb,    // not decoded, all registers are full words
  output logic               pready,
  output logic [31:0]        prdata,
  output logic               pslverr,
  output logic               sclk,
  output logic [cs_num-1:0]  cs_n,
  output logic               mosi,
  input  logic               miso,
  output logic               irq
);

  spi_xip_pkg::apb_req_t    req;
  spi_xip_pkg::apb_rsp_t    rsp;
  spi_xip_pkg::shift_cmd_t  cmd;
  logic [63:0]              tx_data;
  logic [63:0]              rx_data;
  logic                     busy;
  logic                     done;
  logic                     irq_flag;

  xip_bridge #(
    .flash_base (flash_base),
    .flash_limit(flash_limit)
  ) u_bridge (
    .clk     (clk),
    .resetn  (resetn),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pready  (pready),
    .prdata  (prdata),
    .pslverr (pslverr),
    .req     (req),
    .rsp     (rsp),
    .irq_flag(irq_flag),
    .irq     (irq)
  );

  spi_regs #(
    .cs_num(cs_num)
  ) u_regs (
    .clk     (clk),
    .resetn  (resetn),
    .req     (req),
    .rsp     (rsp),
    .cmd     (cmd),
    .tx_data (tx_data),
    .busy    (busy),
    .done    (done),
    .rx_data (rx_data),
    .irq_flag(irq_flag),
    .cs_n    (cs_n)
  );

  spi_shifter u_shifter (
    .clk    (clk),
    .resetn (resetn),
    .cmd    (cmd),
    .tx_data(tx_data),
    .sclk   (sclk),
    .mosi   (mosi),
    .miso   (miso),
    .busy   (busy),
    .done   (done),
    .rx_data(rx_data)
  );

endmodule

`default_nettype wire

/* tests/spi_flash_model.sv */
// behavioral SPI flash, read command only
// takes opcode and address on rising sclk, replies with a computed byte pattern
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  logic [31:0] cmd_sr;
  logic [23:0] base_addr;
  logic        reading;
  int          bit_cnt;

  // content of one flash byte
  function automatic logic [7:0] pattern_byte(input logic [23:0] a);
    return a[7:0] ^ 8'h5a ^ a[15:8];
  endfunction

  initial begin
    cmd_sr    = '0;
    base_addr = '0;
    reading   = 1'b0;
    bit_cnt   = 0;
    miso      = 1'b0;
  end

  always @(negedge cs_n) begin
    bit_cnt = 0;
    reading = 1'b0;
    miso    = 1'b0;
  end

  always @(posedge sclk) begin
    if (!cs_n) begin
      if (bit_cnt < 32) begin
        cmd_sr = {cmd_sr[30:0], mosi};
        if (bit_cnt == 31) begin  // opcode and address complete
          reading   = (cmd_sr[31:24] == 8'h03);
          base_addr = cmd_sr[23:0];
        end
      end
      bit_cnt = bit_cnt + 1;
    end
  end

  // data bits change on falling sclk, msb of each byte first
  always @(negedge sclk) begin
    int         idx;
    logic [7:0] data;
    if (!cs_n && reading && (bit_cnt >= 32) && (bit_cnt < 64)) begin
      idx  = bit_cnt - 32;
      data = pattern_byte(base_addr + 24'(idx >> 3));
      miso = data[7 - (idx % 8)];
    end
  end

endmodule

`default_nettype wire

/* tests/spi_xip_chk.sv */
// pin level checks for the SPI XIP controller
// APB completion, chip select exclusivity and an idle serial clock
`timescale 1ns/1ps
`default_nettype none

module spi_xip_chk #(
  parameter int cs_num = 2
) (
  input logic              clk,
  input logic              resetn,
  input logic              psel,
  input logic              penable,
  input logic              pready,
  input logic              sclk,
  input logic [cs_num-1:0] cs_n
);

  a_ready_in_access: assert property (@(posedge clk) disable iff (!resetn)
    $rose(pready) |-> (psel && penable))
    else $error("pready rose outside an APB access phase");

  a_one_cs: assert property (@(posedge clk) disable iff (!resetn)
    $onehot0(~cs_n))
    else $error("more than one chip select active");

  // the last falling edge shares its clock with the deselect
  a_sclk_idle: assert property (@(posedge clk) disable iff (!resetn)
    (&cs_n && $past(&cs_n)) |-> $stable(sclk))
    else $error("sclk moved while no device was selected");

endmodule

bind spi_xip_top spi_xip_chk #(.cs_num(cs_num)) u_chk (
  .clk    (clk),
  .resetn (resetn),
  .psel   (psel),
  .penable(penable),
  .pready (pready),
  .sclk   (sclk),
  .cs_n   (cs_n)
);

`default_nettype wire

/* tests/tb_spi_xip.sv */
// SPI XIP controller testbench
// random flash reads, register access and a manual transfer against a flash model
`timescale 1ns/1ps
`default_nettype none

module tb_spi_xip;

  localparam int          clk_period   = 10;
  localparam int          reset_cycles = 5;
  localparam int          cs_count     = 2;
  localparam int          num_reads    = 40;
  localparam int          max_div      = 3;
  localparam int          read_clocks  = 64 * 2 * (max_div + 1) + 64;  // serial phase plus steps
  localparam int          timeout_ns   = 200 * read_clocks * 2 * clk_period;
  localparam int          max_polls    = 1000;
  localparam logic [31:0] flash_base   = 32'h3000_0000;
  localparam logic [31:0] csr_base     = 32'h2000_0000;
  localparam logic [31:0] reg_rxd0     = 32'h00;
  localparam logic [31:0] reg_txd0     = 32'h00;
  localparam logic [31:0] reg_txd1     = 32'h04;
  localparam logic [31:0] reg_ctl      = 32'h10;
  localparam logic [31:0] reg_div      = 32'h14;
  localparam logic [31:0] reg_cs       = 32'h18;
  localparam logic [31:0] ctl_go       = 32'h0000_0100;
  // ie, ass, rd_endian, launch on falling sclk, 64 bits
  localparam logic [31:0] ctl_mode     = 32'h1000 | 32'h2000 | 32'h4000 | 32'h0400 | 32'h40;
  localparam logic [cs_count-1:0] cs_idle = '1;

  logic                clk;
  logic                resetn;
  logic [31:0]         paddr;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [31:0]         pwdata;
  logic [3:0]          pstrb;
  logic                pready;
  logic [31:0]         prdata;
  logic                pslverr;
  logic                sclk;
  logic [cs_count-1:0] cs_n;
  logic                mosi;
  logic                miso;
  logic                irq;

  int                  errors;
  int                  checks;
  int                  tests_run;
  int                  tests_failed;
  int                  test_errors;
  string               cur_test;
  logic                watch;
  logic                irq_seen;
  logic                cs0_low;
  logic                other_low;
  logic [cs_count-1:0] ready_cs_n;

  spi_xip_top #(
    .flash_base (flash_base),
    .flash_limit(32'h3fff_ffff),
    .cs_num     (cs_count)
  ) u_dut (
    .clk    (clk),
    .resetn (resetn),
    .paddr  (paddr),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .pwdata (pwdata),
    .pstrb  (pstrb),
    .pready (pready),
    .prdata (prdata),
    .pslverr(pslverr),
    .sclk   (sclk),
    .cs_n   (cs_n),
    .mosi   (mosi),
    .miso   (miso),
    .irq    (irq)
  );

  spi_flash_model u_flash (
    .sclk(sclk),
    .cs_n(cs_n[0]),
    .mosi(mosi),
    .miso(miso)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired, the tests did not finish in time");
    $display("Testbench failed");
    $finish;
  end

  // pin activity while a flash access is running
  always @(negedge clk) begin
    if (watch) begin
      if (irq) irq_seen = 1'b1;
      if (!cs_n[0]) cs0_low = 1'b1;
      if (!(&cs_n[cs_count-1:1])) other_low = 1'b1;
    end
  end

  // byte k of a read reply is the pattern of address + k
  function automatic logic [7:0] flash_byte(input logic [23:0] a);
    return a[7:0] ^ 8'h5a ^ a[15:8];
  endfunction

  // lowest address lands in bits 7:0 after the rd_endian swap
  function automatic logic [31:0] flash_word(input logic [23:0] a);
    return {flash_byte(a + 24'd3), flash_byte(a + 24'd2), flash_byte(a + 24'd1), flash_byte(a)};
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERROR %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors != test_errors) begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", cur_test, errors - test_errors);
    end else begin
      $display("%s: ok", cur_test);
    end
  endtask

  task automatic watch_start();
    irq_seen  = 1'b0;
    cs0_low   = 1'b0;
    other_low = 1'b0;
    watch     = 1'b1;
  endtask

  // one APB transfer, entered and left 1 ns after a rising edge
  task automatic apb_transfer(input logic [31:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err, output int cycles);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    cycles  = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!pready && (cycles < 2 * read_clocks));
    if (!pready) begin
      errors++;
      $display("%s: no pready within %0d clocks at address 0x%h", cur_test, cycles, addr);
    end
    rdata      = prdata;
    err        = pslverr;
    ready_cs_n = cs_n;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic csr_write(input logic [31:0] offset, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    apb_transfer(csr_base + offset, 1'b1, data, rdata, err, cycles);
    check_value("csr write pslverr", 0, err);
    check_value("csr write latency", 3, cycles);
  endtask

  task automatic csr_read(input logic [31:0] offset, output logic [31:0] data);
    logic err;
    int   cycles;
    apb_transfer(csr_base + offset, 1'b0, 32'h0, data, err, cycles);
    check_value("csr read pslverr", 0, err);
    check_value("csr read latency", 3, cycles);
  endtask

  initial begin
    logic [31:0]  rdata;
    logic [31:0]  addr;
    logic [31:0]  cs_val;
    logic [23:0]  faddr;
    logic [15:0]  div_val;
    logic         err;
    int           cycles;
    int           polls;
    void'($urandom(32'hffed));
    errors  = 0;
    checks  = 0;
    watch   = 1'b0;
    resetn  = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    pstrb   = 4'hf;
    repeat (reset_cycles) @(posedge clk);
    #1;
    resetn = 1'b1;
    @(posedge clk);
    #1;

    for (int i = 0; i < num_reads; i++) begin
      begin_test($sformatf("flash_read_%0d", i));
      csr_write(reg_div, $urandom_range(max_div, 0));
      addr = flash_base + ($urandom & 32'h0fff_fffc);
      watch_start();
      apb_transfer(addr, 1'b0, 32'h0, rdata, err, cycles);
      watch = 1'b0;
      check_value("rdata", flash_word(addr[23:0]), rdata);
      check_value("pslverr", 0, err);
      check_value("cs_n at pready", cs_idle, ready_cs_n);
      check_value("cs_n[0] went low", 1, cs0_low);
      check_value("other cs_n went low", 0, other_low);
      check_value("irq during read", 0, irq_seen);
      end_test();
    end

    begin_test("div_cs_rw");
    div_val = 16'($urandom);
    csr_write(reg_div, {16'h0, div_val});
    csr_read(reg_div, rdata);
    check_value("div", div_val, rdata);
    cs_val = $urandom & ((32'd1 << cs_count) - 1);
    csr_write(reg_cs, cs_val);
    csr_read(reg_cs, rdata);
    check_value("cs", cs_val, rdata);
    csr_write(reg_cs, 32'h0);
    end_test();

    begin_test("manual_xfer");
    csr_write(reg_div, $urandom_range(max_div, 0));
    faddr = 24'($urandom);
    csr_write(reg_txd1, {8'h03, faddr});
    csr_write(reg_txd0, 32'h0);
    csr_write(reg_ctl, ctl_mode | ctl_go);
    check_value("irq while busy", 0, irq);
    polls = 0;
    do begin
      csr_read(reg_ctl, rdata);
      polls++;
    end while (((rdata & ctl_go) != 0) && (polls < max_polls));
    if ((rdata & ctl_go) != 0) begin
      errors++;
      $display("%s: GO bit still set after %0d polls", cur_test, polls);
    end
    check_value("irq after done", 1, irq);
    csr_read(reg_rxd0, rdata);
    check_value("rxd0", flash_word(faddr), rdata);
    csr_write(reg_ctl, ctl_mode);
    check_value("irq after ctl write", 0, irq);
    end_test();

    begin_test("flash_write");
    watch_start();
    apb_transfer(flash_base + ($urandom & 32'h0fff_fffc), 1'b1, $urandom, rdata, err, cycles);
    watch = 1'b0;
    check_value("pslverr", 1, err);
    check_value("latency", 1, cycles);
    check_value("cs_n went low", 0, cs0_low | other_low);
    end_test();

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
verilog/spi_xip_pkg.sv
verilog/xip_bridge.sv
verilog/spi_regs.sv
verilog/spi_shifter.sv
verilog/spi_xip_top.sv
tests/spi_flash_model.sv
tests/spi_xip_chk.sv
tests/tb_spi_xip.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the SPI XIP testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_spi_xip -f filelist.f \
  && ./obj_dir/Vtb_spi_xip > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Testbench failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation PASSED"
exit 0
